// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tbMips
FILELIST  := vlog.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== execUnit.sv ====
module execUnit (
    input  mipsPkg::idEx_t   ex_i,
    input  mipsPkg::fwdSel_t fwdA_i,
    input  mipsPkg::fwdSel_t fwdB_i,
    input  mipsPkg::word_t   memFwd_i,
    input  mipsPkg::word_t   wbFwd_i,
    output mipsPkg::exMem_t  exMem_o,
    output logic             branchTaken_o,
    output mipsPkg::word_t   branchTarget_o
);

    mipsPkg::word_t    srcA;
    mipsPkg::word_t    rtFwd;
    mipsPkg::word_t    srcB;
    mipsPkg::word_t    aluRes;
    mipsPkg::regAddr_t wReg;

    function automatic mipsPkg::word_t pick(input mipsPkg::fwdSel_t sel,
                                            input mipsPkg::word_t regVal,
                                            input mipsPkg::word_t memVal,
                                            input mipsPkg::word_t wbVal);
        case (sel)
            mipsPkg::FROM_MEM: return memVal;
            mipsPkg::FROM_WB:  return wbVal;
            default:           return regVal;
        endcase
    endfunction

    assign srcA = pick(fwdA_i, ex_i.rsVal, memFwd_i, wbFwd_i);
    assign rtFwd = pick(fwdB_i, ex_i.rtVal, memFwd_i, wbFwd_i);
    assign srcB = ex_i.ctrl.aluSrcImm ? ex_i.imm : rtFwd;

    always_comb begin
        case (ex_i.ctrl.aluOp)
            mipsPkg::SUB: aluRes = srcA - srcB;
            mipsPkg::AND: aluRes = srcA & srcB;
            mipsPkg::OR:  aluRes = srcA | srcB;
            mipsPkg::SLT: aluRes = {31'b0, $signed(srcA) < $signed(srcB)};
            mipsPkg::LUI: aluRes = {srcB[15:0], 16'b0};
            default:      aluRes = srcA + srcB;
        endcase
    end

    always_comb begin
        case (ex_i.ctrl.regDst)
            mipsPkg::DST_RT: wReg = ex_i.rt;
            mipsPkg::DST_RA: wReg = 5'd31;
            default:         wReg = ex_i.rd;
        endcase
    end

    // beq/bne compare the forwarded register values
    assign branchTaken_o = ex_i.ctrl.isBranch & ((srcA == rtFwd) ^ ex_i.ctrl.branchNe);
    assign branchTarget_o = ex_i.pcPlus4 + {ex_i.imm[29:0], 2'b00};

    assign exMem_o = '{
        pc:        ex_i.pc,
        aluOut:    ex_i.ctrl.isLink ? ex_i.pcPlus4 + 32'd4 : aluRes,  // link skips delay slot
        storeData: rtFwd,
        wReg:      wReg,
        ctrl:      ex_i.ctrl
    };

endmodule

// ==== fetchUnit.sv ====
module fetchUnit (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           stall_i,
    input  logic           branchTaken_i,
    input  mipsPkg::word_t branchTarget_i,
    input  mipsPkg::word_t instrD_i,
    input  mipsPkg::word_t pcPlus4D_i,
    output mipsPkg::word_t pc_o,
    output mipsPkg::word_t pcPlus4_o,
    output logic           instEn_o
);

    logic           jumpD;
    mipsPkg::word_t pcNext;

    // j and jal redirect straight out of decode
    assign jumpD = (instrD_i[31:26] == mipsPkg::OP_J) || (instrD_i[31:26] == mipsPkg::OP_JAL);
    assign pcPlus4_o = pc_o + 32'd4;

    always_comb begin
        if (branchTaken_i) begin
            pcNext = branchTarget_i;
        end else if (jumpD) begin
            pcNext = {pcPlus4D_i[31:28], instrD_i[25:0], 2'b00};  // region of the delay slot
        end else begin
            pcNext = pcPlus4_o;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_o <= mipsPkg::RESET_PC;
        end else if (!stall_i) begin
            pc_o <= pcNext;
        end
    end

    assign instEn_o = ~rst_i;

endmodule

// ==== memAccess.sv ====
module memAccess (
    input  mipsPkg::exMem_t m_i,
    input  mipsPkg::word_t  memRdata_i,
    output logic            memEn_o,
    output mipsPkg::word_t  memAddr_o,
    output logic [3:0]      memWen_o,
    output mipsPkg::word_t  memWdata_o,
    output mipsPkg::word_t  result_o,
    output mipsPkg::word_t  memFwd_o,
    output mipsPkg::memWb_t wb_o
);

    assign memEn_o = m_i.ctrl.memRead | m_i.ctrl.memWrite;
    assign memAddr_o = m_i.aluOut;
    assign memWen_o = {4{m_i.ctrl.memWrite}};  // word stores only
    assign memWdata_o = m_i.storeData;

    assign result_o = m_i.ctrl.memRead ? memRdata_i : m_i.aluOut;
    // load data never takes the memory-stage bypass
    assign memFwd_o = m_i.aluOut;

    // writes to $0 are dropped here
    assign wb_o = '{
        result:   result_o,
        wReg:     m_i.wReg,
        regWrite: m_i.ctrl.regWrite && (m_i.wReg != '0)
    };

endmodule

// ==== mipsCore.sv ====
module mipsCore (
    input  logic              clk,
    input  logic              rst_i,
    input  mipsPkg::word_t    instr_i,
    input  logic              iStall_i,
    input  mipsPkg::word_t    memRdata_i,
    input  logic              dStall_i,
    output mipsPkg::word_t    pc_o,
    output logic              instEn_o,
    output logic              memEn_o,
    output mipsPkg::word_t    memAddr_o,
    output logic [3:0]        memWen_o,
    output mipsPkg::word_t    memWdata_o,
    output mipsPkg::word_t    dbgPc_o,
    output logic [3:0]        dbgRfWen_o,
    output mipsPkg::regAddr_t dbgRfWnum_o,
    output mipsPkg::word_t    dbgRfWdata_o
);

    logic stallF, stallD, stallE, stallM;
    logic flushD, flushE;
    logic branchTaken;
    mipsPkg::fwdSel_t fwdA, fwdB;
    mipsPkg::word_t pcPlus4F, branchTarget, immD, rsValD, rtValD, resultM, memFwdM;
    mipsPkg::ctrl_t ctrlD;
    mipsPkg::ifId_t ifIdD, ifIdQ;
    mipsPkg::idEx_t idExD, idExQ;
    mipsPkg::exMem_t exMemD, exMemQ;
    mipsPkg::memWb_t wbM, memWbQ;

    fetchUnit fetch (
        .clk(clk), .rst_i(rst_i), .stall_i(stallF),
        .branchTaken_i(branchTaken), .branchTarget_i(branchTarget),
        .instrD_i(ifIdQ.instr), .pcPlus4D_i(ifIdQ.pcPlus4),
        .pc_o(pc_o), .pcPlus4_o(pcPlus4F), .instEn_o(instEn_o)
    );

    assign ifIdD = '{pc: pc_o, pcPlus4: pcPlus4F, instr: instr_i};

    stageReg #(.payload_t(mipsPkg::ifId_t)) ifIdReg (
        .clk(clk), .rst_i(rst_i), .stall_i(stallD), .flush_i(flushD), .d_i(ifIdD), .q_o(ifIdQ)
    );

    pipeCtrl ctrl (
        .instrD_i(ifIdQ.instr), .exStage_i(idExQ), .memStage_i(exMemQ), .wbStage_i(memWbQ),
        .branchTaken_i(branchTaken), .iStall_i(iStall_i), .dStall_i(dStall_i),
        .ctrlD_o(ctrlD), .immD_o(immD),
        .stallF_o(stallF), .stallD_o(stallD), .stallE_o(stallE), .stallM_o(stallM),
        .flushD_o(flushD), .flushE_o(flushE), .fwdA_o(fwdA), .fwdB_o(fwdB)
    );

    // written from the memory stage at commit
    regFile rf (
        .clk(clk), .we_i(wbM.regWrite),
        .ra1_i(ifIdQ.instr[25:21]), .ra2_i(ifIdQ.instr[20:16]),
        .wa_i(wbM.wReg), .wd_i(resultM), .rd1_o(rsValD), .rd2_o(rtValD)
    );

    assign idExD = '{
        pc: ifIdQ.pc, pcPlus4: ifIdQ.pcPlus4, rsVal: rsValD, rtVal: rtValD, imm: immD,
        rs: ifIdQ.instr[25:21], rt: ifIdQ.instr[20:16], rd: ifIdQ.instr[15:11], ctrl: ctrlD
    };

    stageReg #(.payload_t(mipsPkg::idEx_t)) idExReg (
        .clk(clk), .rst_i(rst_i), .stall_i(stallE), .flush_i(flushE), .d_i(idExD), .q_o(idExQ)
    );

    execUnit exec (
        .ex_i(idExQ), .fwdA_i(fwdA), .fwdB_i(fwdB), .memFwd_i(memFwdM),
        .wbFwd_i(memWbQ.result), .exMem_o(exMemD),
        .branchTaken_o(branchTaken), .branchTarget_o(branchTarget)
    );

    stageReg #(.payload_t(mipsPkg::exMem_t)) exMemReg (
        .clk(clk), .rst_i(rst_i), .stall_i(stallM), .flush_i(1'b0), .d_i(exMemD), .q_o(exMemQ)
    );

    memAccess mem (
        .m_i(exMemQ), .memRdata_i(memRdata_i),
        .memEn_o(memEn_o), .memAddr_o(memAddr_o), .memWen_o(memWen_o), .memWdata_o(memWdata_o),
        .result_o(resultM), .memFwd_o(memFwdM), .wb_o(wbM)
    );

    stageReg #(.payload_t(mipsPkg::memWb_t)) memWbReg (
        .clk(clk), .rst_i(rst_i), .stall_i(stallM), .flush_i(1'b0), .d_i(wbM), .q_o(memWbQ)
    );

    // held while stalled, the commit takes effect on an unstalled edge
    assign dbgPc_o = exMemQ.pc;
    assign dbgRfWen_o = {4{wbM.regWrite}};
    assign dbgRfWnum_o = wbM.wReg;
    assign dbgRfWdata_o = resultM;

endmodule

// ==== mipsPkg.sv ====
package mipsPkg;

    localparam int XLEN = 32;
    localparam int REG_AW = 5;
    localparam logic [XLEN-1:0] RESET_PC = 32'hBFC00000;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // SPECIAL function field
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    // write register choice
    localparam logic [1:0] DST_RD = 2'd0;
    localparam logic [1:0] DST_RT = 2'd1;
    localparam logic [1:0] DST_RA = 2'd2;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_AW-1:0] regAddr_t;

    typedef enum logic [2:0] {ADD, SUB, AND, OR, SLT, LUI} aluOp_t;
    typedef enum logic [1:0] {REGFILE, FROM_MEM, FROM_WB} fwdSel_t;

    typedef struct packed {
        logic       regWrite;
        logic       memRead;
        logic       memWrite;
        logic       aluSrcImm;
        logic       signExt;
        logic       isBranch;
        logic       branchNe;
        logic       isLink;
        aluOp_t     aluOp;
        logic [1:0] regDst;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t pcPlus4;
        word_t instr;
    } ifId_t;

    typedef struct packed {
        word_t    pc;
        word_t    pcPlus4;
        word_t    rsVal;
        word_t    rtVal;
        word_t    imm;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        ctrl_t    ctrl;
    } idEx_t;

    typedef struct packed {
        word_t    pc;
        word_t    aluOut;
        word_t    storeData;
        regAddr_t wReg;
        ctrl_t    ctrl;
    } exMem_t;

    typedef struct packed {
        word_t    result;
        regAddr_t wReg;
        logic     regWrite;
    } memWb_t;

endpackage

// ==== pipeCtrl.sv ====
module pipeCtrl (
    input  mipsPkg::word_t   instrD_i,
    input  mipsPkg::idEx_t   exStage_i,
    input  mipsPkg::exMem_t  memStage_i,
    input  mipsPkg::memWb_t  wbStage_i,
    input  logic             branchTaken_i,
    input  logic             iStall_i,
    input  logic             dStall_i,
    output mipsPkg::ctrl_t   ctrlD_o,
    output mipsPkg::word_t   immD_o,
    output logic             stallF_o,
    output logic             stallD_o,
    output logic             stallE_o,
    output logic             stallM_o,
    output logic             flushD_o,
    output logic             flushE_o,
    output mipsPkg::fwdSel_t fwdA_o,
    output mipsPkg::fwdSel_t fwdB_o
);

    logic [5:0]        op;
    logic [5:0]        funct;
    mipsPkg::regAddr_t rsD;
    mipsPkg::regAddr_t rtD;
    logic              usesRs;
    logic              usesRt;
    logic              loadUse;
    logic              stallAll;

    function automatic mipsPkg::fwdSel_t fwdFor(input mipsPkg::regAddr_t src,
                                                input mipsPkg::exMem_t m,
                                                input mipsPkg::memWb_t w);
        if (m.ctrl.regWrite && m.wReg != '0 && m.wReg == src) begin
            return mipsPkg::FROM_MEM;  // youngest producer wins
        end else if (w.regWrite && w.wReg == src) begin
            return mipsPkg::FROM_WB;
        end
        return mipsPkg::REGFILE;
    endfunction

    assign op = instrD_i[31:26];
    assign funct = instrD_i[5:0];
    assign rsD = instrD_i[25:21];
    assign rtD = instrD_i[20:16];

    always_comb begin
        ctrlD_o = '0;
        case (op)
            mipsPkg::OP_SPECIAL: begin
                ctrlD_o.regWrite = 1'b1;
                ctrlD_o.regDst = mipsPkg::DST_RD;
                case (funct)
                    mipsPkg::FN_ADDU: ctrlD_o.aluOp = mipsPkg::ADD;
                    mipsPkg::FN_SUBU: ctrlD_o.aluOp = mipsPkg::SUB;
                    mipsPkg::FN_AND:  ctrlD_o.aluOp = mipsPkg::AND;
                    mipsPkg::FN_OR:   ctrlD_o.aluOp = mipsPkg::OR;
                    mipsPkg::FN_SLT:  ctrlD_o.aluOp = mipsPkg::SLT;
                    default:          ctrlD_o.regWrite = 1'b0;  // nop
                endcase
            end
            mipsPkg::OP_ADDIU, mipsPkg::OP_LW: begin
                ctrlD_o.regWrite = 1'b1;
                ctrlD_o.memRead = (op == mipsPkg::OP_LW);
                ctrlD_o.aluSrcImm = 1'b1;
                ctrlD_o.signExt = 1'b1;
                ctrlD_o.aluOp = mipsPkg::ADD;
                ctrlD_o.regDst = mipsPkg::DST_RT;
            end
            mipsPkg::OP_ORI, mipsPkg::OP_LUI: begin
                ctrlD_o.regWrite = 1'b1;
                ctrlD_o.aluSrcImm = 1'b1;
                ctrlD_o.aluOp = (op == mipsPkg::OP_ORI) ? mipsPkg::OR : mipsPkg::LUI;
                ctrlD_o.regDst = mipsPkg::DST_RT;
            end
            mipsPkg::OP_SW: begin
                ctrlD_o.memWrite = 1'b1;
                ctrlD_o.aluSrcImm = 1'b1;
                ctrlD_o.signExt = 1'b1;
                ctrlD_o.aluOp = mipsPkg::ADD;
            end
            mipsPkg::OP_BEQ, mipsPkg::OP_BNE: begin
                ctrlD_o.isBranch = 1'b1;
                ctrlD_o.branchNe = (op == mipsPkg::OP_BNE);
                ctrlD_o.signExt = 1'b1;  // offset is signed
            end
            mipsPkg::OP_JAL: begin
                ctrlD_o.regWrite = 1'b1;
                ctrlD_o.isLink = 1'b1;
                ctrlD_o.regDst = mipsPkg::DST_RA;
            end
            default: ctrlD_o = '0;  // j and unknown opcodes
        endcase
    end

    assign immD_o = ctrlD_o.signExt ? {{16{instrD_i[15]}}, instrD_i[15:0]}
                                    : {16'b0, instrD_i[15:0]};

    // only real source operands can cause a load-use stall
    assign usesRs = !(op == mipsPkg::OP_J || op == mipsPkg::OP_JAL || op == mipsPkg::OP_LUI);
    assign usesRt = (op == mipsPkg::OP_SPECIAL) || (op == mipsPkg::OP_BEQ) ||
                    (op == mipsPkg::OP_BNE) || (op == mipsPkg::OP_SW);

    assign loadUse = (exStage_i.ctrl.memRead && exStage_i.rt != '0 &&
                      ((usesRs && exStage_i.rt == rsD) || (usesRt && exStage_i.rt == rtD))) ||
                     (memStage_i.ctrl.memRead && memStage_i.wReg != '0 &&
                      ((usesRs && memStage_i.wReg == rsD) || (usesRt && memStage_i.wReg == rtD)));

    assign fwdA_o = fwdFor(exStage_i.rs, memStage_i, wbStage_i);
    assign fwdB_o = fwdFor(exStage_i.rt, memStage_i, wbStage_i);

    assign stallAll = iStall_i | dStall_i;
    // a taken branch still moves the PC while decode waits on a load
    assign stallF_o = stallAll | (loadUse & ~branchTaken_i);
    assign stallD_o = stallAll | loadUse;
    assign stallE_o = stallAll;
    assign stallM_o = stallAll;
    assign flushD_o = branchTaken_i & ~stallD_o;  // held delay slot is kept
    assign flushE_o = loadUse & ~stallAll;

endmodule

// ==== regFile.sv ====
module regFile (
    input  logic              clk,
    input  logic              we_i,
    input  mipsPkg::regAddr_t ra1_i,
    input  mipsPkg::regAddr_t ra2_i,
    input  mipsPkg::regAddr_t wa_i,
    input  mipsPkg::word_t    wd_i,
    output mipsPkg::word_t    rd1_o,
    output mipsPkg::word_t    rd2_o
);

    mipsPkg::word_t regs [2**mipsPkg::REG_AW];

    always_ff @(posedge clk) begin
        if (we_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    // $0 reads zero, a same-cycle write is passed through
    assign rd1_o = (ra1_i == '0) ? '0 : (we_i && wa_i == ra1_i) ? wd_i : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : (we_i && wa_i == ra2_i) ? wd_i : regs[ra2_i];

endmodule

// ==== stageReg.sv ====
module stageReg #(
    parameter type payload_t = mipsPkg::word_t
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            q_o <= '0;  // bubble
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

// ==== tbMips.sv ====
module tbMips;

    typedef struct packed {
        mipsPkg::word_t    pc;
        mipsPkg::regAddr_t wReg;
        mipsPkg::word_t    data;
    } commit_t;

    typedef struct packed {
        mipsPkg::word_t addr;
        mipsPkg::word_t data;
    } store_t;

    logic              clk;
    logic              rst_i;
    logic              iStall_i;
    logic              dStall_i;
    mipsPkg::word_t    instr_i;
    mipsPkg::word_t    memRdata_i;
    mipsPkg::word_t    pc_o;
    logic              instEn_o;
    logic              memEn_o;
    mipsPkg::word_t    memAddr_o;
    logic [3:0]        memWen_o;
    mipsPkg::word_t    memWdata_o;
    mipsPkg::word_t    dbgPc_o;
    logic [3:0]        dbgRfWen_o;
    mipsPkg::regAddr_t dbgRfWnum_o;
    mipsPkg::word_t    dbgRfWdata_o;

    mipsPkg::word_t rom [64];
    mipsPkg::word_t ram [256];
    mipsPkg::word_t modelRam [256];
    mipsPkg::word_t modelRegs [32];
    mipsPkg::word_t pcOff;
    commit_t        expCommit [$];
    store_t         expStore [$];
    int             progLen;
    int             commitBudget;
    int             cycleCount;
    logic           randomStalls;
    logic [31:0]    rngState;

    mipsCore UUT (.*);

    assign pcOff = pc_o - mipsPkg::RESET_PC;
    assign instr_i = (pcOff[31:8] == 24'h0) ? rom[pcOff[7:2]] : 32'h0;  // nops past the ROM
    assign memRdata_i = ram[memAddr_o[9:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input mipsPkg::word_t got,
                             input mipsPkg::word_t exp);
        if (got !== exp) begin
            failRun($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic checkReg(input string name, input mipsPkg::regAddr_t got,
                            input mipsPkg::regAddr_t exp);
        if (got !== exp) begin
            failRun($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic checkEnable(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            failRun($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    function automatic mipsPkg::word_t rFormat(input logic [5:0] fn, input mipsPkg::regAddr_t rd,
                                               input mipsPkg::regAddr_t rs,
                                               input mipsPkg::regAddr_t rt);
        return {6'h00, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic mipsPkg::word_t iFormat(input logic [5:0] op, input mipsPkg::regAddr_t rt,
                                               input mipsPkg::regAddr_t rs,
                                               input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mipsPkg::word_t jFormat(input logic [5:0] op, input mipsPkg::word_t target);
        return {op, target[27:2]};
    endfunction

    task automatic appendInstr(input mipsPkg::word_t w);
        rom[progLen[5:0]] = w;
        progLen++;
    endtask

    // core held in reset while the ROM is rewritten
    task automatic clearProgram;
        randomStalls = 1'b0;
        @(negedge clk);
        rst_i = 1'b1;
        progLen = 0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = 32'h0;
        end
    endtask

    // ISA walk over the delay slots fills the expected queues
    task automatic modelProgram;
        mipsPkg::word_t    pc, npc, nxt, ins, a, b, imm, res, addr, off;
        mipsPkg::regAddr_t dst;
        logic              wr;
        int                steps;
        pc = mipsPkg::RESET_PC;
        npc = pc + 32'd4;
        steps = 0;
        off = 32'h0;
        while (int'(off >> 2) < progLen && steps < 200) begin
            ins = rom[off[7:2]];
            a = modelRegs[ins[25:21]];
            b = modelRegs[ins[20:16]];
            imm = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm;
            nxt = npc + 32'd4;
            wr = 1'b1;
            dst = ins[20:16];
            res = 32'h0;
            case (ins[31:26])
                mipsPkg::OP_SPECIAL: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        mipsPkg::FN_ADDU: res = a + b;
                        mipsPkg::FN_SUBU: res = a - b;
                        mipsPkg::FN_AND:  res = a & b;
                        mipsPkg::FN_OR:   res = a | b;
                        mipsPkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:          wr = 1'b0;
                    endcase
                end
                mipsPkg::OP_ADDIU: res = a + imm;
                mipsPkg::OP_ORI:   res = a | {16'h0, ins[15:0]};
                mipsPkg::OP_LUI:   res = {ins[15:0], 16'h0};
                mipsPkg::OP_LW:    res = modelRam[addr[9:2]];
                mipsPkg::OP_SW: begin
                    wr = 1'b0;
                    modelRam[addr[9:2]] = b;
                    expStore.push_back('{addr: addr, data: b});
                end
                mipsPkg::OP_BEQ, mipsPkg::OP_BNE: begin
                    wr = 1'b0;
                    if ((a == b) ^ (ins[31:26] == mipsPkg::OP_BNE)) begin
                        nxt = npc + {imm[29:0], 2'b00};  // relative to the delay slot
                    end
                end
                mipsPkg::OP_J: begin
                    wr = 1'b0;
                    nxt = {npc[31:28], ins[25:0], 2'b00};
                end
                mipsPkg::OP_JAL: begin
                    nxt = {npc[31:28], ins[25:0], 2'b00};
                    dst = 5'd31;
                    res = pc + 32'd8;
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                modelRegs[dst] = res;
                expCommit.push_back('{pc: pc, wReg: dst, data: res});
            end
            pc = npc;
            npc = nxt;
            off = pc - mipsPkg::RESET_PC;
            steps++;
        end
    endtask

    task automatic runProgram(input logic stalls);
        modelProgram();
        commitBudget += expCommit.size();
        repeat (2) @(negedge clk);
        rst_i = 1'b0;
        #10;
        checkWord("pc_o", pc_o, mipsPkg::RESET_PC);
        checkEnable("instEn_o", {3'b000, instEn_o}, 4'h1);
        checkEnable("memEn_o", {3'b000, memEn_o}, 4'h0);
        checkEnable("dbgRfWen_o", dbgRfWen_o, 4'h0);
        randomStalls = stalls;
        while (expCommit.size() > 0 || expStore.size() > 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);  // catch any extra commit
    endtask

    task automatic testAlu(input logic stalls);
        clearProgram();
        appendInstr(iFormat(mipsPkg::OP_LUI, 5'd1, 5'd0, 16'h1234));
        appendInstr(iFormat(mipsPkg::OP_ORI, 5'd1, 5'd1, 16'h5678));
        appendInstr(iFormat(mipsPkg::OP_ADDIU, 5'd2, 5'd0, 16'hfffb));
        appendInstr(32'h0);
        appendInstr(32'h0);
        appendInstr(rFormat(mipsPkg::FN_ADDU, 5'd3, 5'd1, 5'd2));
        appendInstr(rFormat(mipsPkg::FN_SUBU, 5'd4, 5'd1, 5'd2));
        appendInstr(rFormat(mipsPkg::FN_AND, 5'd5, 5'd1, 5'd2));
        appendInstr(rFormat(mipsPkg::FN_OR, 5'd6, 5'd1, 5'd2));
        appendInstr(rFormat(mipsPkg::FN_SLT, 5'd7, 5'd2, 5'd1));
        appendInstr(rFormat(mipsPkg::FN_SLT, 5'd8, 5'd1, 5'd2));
        appendInstr(iFormat(mipsPkg::OP_ADDIU, 5'd0, 5'd1, 16'h0001));  // $0 stays silent
        runProgram(stalls);
    endtask

    task automatic testForward(input logic stalls);
        clearProgram();
        appendInstr(iFormat(mipsPkg::OP_ADDIU, 5'd1, 5'd0, 16'h0007));
        appendInstr(rFormat(mipsPkg::FN_ADDU, 5'd2, 5'd1, 5'd1));
        appendInstr(rFormat(mipsPkg::FN_ADDU, 5'd3, 5'd2, 5'd1));
        appendInstr(rFormat(mipsPkg::FN_SUBU, 5'd4, 5'd3, 5'd2));
        appendInstr(rFormat(mipsPkg::FN_OR, 5'd5, 5'd4, 5'd1));
        appendInstr(rFormat(mipsPkg::FN_SLT, 5'd6, 5'd4, 5'd5));
        runProgram(stalls);
    endtask

    task automatic testLoadUse(input logic stalls);
        clearProgram();
        appendInstr(iFormat(mipsPkg::OP_ADDIU, 5'd1, 5'd0, 16'h0040));
        appendInstr(iFormat(mipsPkg::OP_LUI, 5'd2, 5'd0, 16'hdead));
        appendInstr(iFormat(mipsPkg::OP_ORI, 5'd2, 5'd2, 16'hbeef));
        appendInstr(iFormat(mipsPkg::OP_SW, 5'd2, 5'd1, 16'h0008));
        appendInstr(iFormat(mipsPkg::OP_LW, 5'd3, 5'd1, 16'h0008));
        appendInstr(rFormat(mipsPkg::FN_ADDU, 5'd4, 5'd3, 5'd3));
        appendInstr(iFormat(mipsPkg::OP_LW, 5'd5, 5'd1, 16'h0000));
        appendInstr(iFormat(mipsPkg::OP_ADDIU, 5'd6, 5'd5, 16'h0001));
        appendInstr(iFormat(mipsPkg::OP_SW, 5'd6, 5'd1, 16'h000c));
        runProgram(stalls);
    endtask

    task automatic testBranch(input logic stalls);
        clearProgram();
        appendInstr(iFormat(mipsPkg::OP_ADDIU, 5'd1, 5'd0, 16'h0003));
        appendInstr(iFormat(mipsPkg::OP_ADDIU, 5'd2, 5'd0, 16'h0003));
        appendInstr(iFormat(mipsPkg::OP_BEQ, 5'd2, 5'd1, 16'h0002));   // taken
        appendInstr(iFormat(mipsPkg::OP_ADDIU, 5'd3, 5'd0, 16'h0001));
        appendInstr(iFormat(mipsPkg::OP_ADDIU, 5'd4, 5'd0, 16'h0002));
        appendInstr(iFormat(mipsPkg::OP_ADDIU, 5'd5, 5'd0, 16'h0005));
        appendInstr(iFormat(mipsPkg::OP_BNE, 5'd2, 5'd1, 16'h0002));   // not taken
        appendInstr(iFormat(mipsPkg::OP_ADDIU, 5'd6, 5'd0, 16'h0006));
        appendInstr(iFormat(mipsPkg::OP_ADDIU, 5'd7, 5'd0, 16'h0007));
        appendInstr(jFormat(mipsPkg::OP_JAL, mipsPkg::RESET_PC + 32'd48));
        appendInstr(iFormat(mipsPkg::OP_ADDIU, 5'd8, 5'd0, 16'h0008));
        appendInstr(iFormat(mipsPkg::OP_ADDIU, 5'd9, 5'd0, 16'h0009));
        appendInstr(iFormat(mipsPkg::OP_ADDIU, 5'd10, 5'd31, 16'h0000));
        runProgram(stalls);
    endtask

    task automatic testRandomStall;
        testAlu(1'b1);
        testForward(1'b1);
        testLoadUse(1'b1);
        testBranch(1'b1);
    endtask

    always @(negedge clk) begin
        if (randomStalls) begin
            rngState = xorshift(rngState);
            iStall_i <= (rngState[1:0] == 2'b00);
            dStall_i <= (rngState[3:2] == 2'b00);
        end else begin
            iStall_i <= 1'b0;
            dStall_i <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!rst_i && !iStall_i && !dStall_i && memEn_o && memWen_o != 4'h0) begin
            ram[memAddr_o[9:2]] <= memWdata_o;
        end
    end

    // a commit or store counts only on an unstalled edge
    always @(posedge clk) begin : traceMonitor
        commit_t c;
        store_t  s;
        if (!rst_i && !iStall_i && !dStall_i) begin
            if (dbgRfWen_o != 4'h0) begin
                if (expCommit.size() == 0) begin
                    failRun("register write reported when no commit was expected");
                end else begin
                    c = expCommit.pop_front();
                    checkEnable("dbgRfWen_o", dbgRfWen_o, 4'hf);
                    checkWord("dbgPc_o", dbgPc_o, c.pc);
                    checkReg("dbgRfWnum_o", dbgRfWnum_o, c.wReg);
                    checkWord("dbgRfWdata_o", dbgRfWdata_o, c.data);
                end
            end
            if (memEn_o && memWen_o != 4'h0) begin
                if (expStore.size() == 0) begin
                    failRun("store seen on the data port when none was expected");
                end else begin
                    s = expStore.pop_front();
                    checkEnable("memWen_o", memWen_o, 4'hf);
                    checkWord("memAddr_o", memAddr_o, s.addr);
                    checkWord("memWdata_o", memWdata_o, s.data);
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_i) begin
            cycleCount++;
            if (cycleCount > 64 * commitBudget) begin
                failRun("watchdog expired before the expected commits arrived");
            end
        end
    end

    initial begin
        rst_i = 1'b1;
        iStall_i = 1'b0;
        dStall_i = 1'b0;
        randomStalls = 1'b0;
        rngState = 32'h7af0b66e;
        commitBudget = 0;
        cycleCount = 0;
        progLen = 0;
        for (int i = 0; i < 256; i++) begin
            ram[i] = mipsPkg::word_t'(i) * 32'h9e3779b1 ^ 32'hc3a50f1e;
            modelRam[i] = ram[i];
        end
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = 32'h0;
        end
        testAlu(1'b0);
        testForward(1'b0);
        testLoadUse(1'b0);
        testBranch(1'b0);
        testRandomStall();
        $display("test passed");
        $finish;
    end

endmodule

// ==== tbMips_sva.sv ====
module tbMips_sva (
    input logic              clk,
    input logic              rst_i,
    input logic              iStall_i,
    input logic              dStall_i,
    input mipsPkg::word_t    pc_o,
    input logic              memEn_o,
    input mipsPkg::word_t    memAddr_o,
    input logic [3:0]        memWen_o,
    input mipsPkg::word_t    memWdata_o,
    input logic [3:0]        dbgRfWen_o,
    input mipsPkg::regAddr_t dbgRfWnum_o
);

    // byte enables only together with a data request
    wenNeedsEn: assert property (@(posedge clk) disable iff (rst_i)
        (memWen_o != 4'h0) |-> memEn_o)
        else $error("memWen_o active without memEn_o");

    // a frozen pipeline holds both request ports
    heldOnStall: assert property (@(posedge clk) disable iff (rst_i)
        (iStall_i || dStall_i) |=> ($stable(pc_o) && $stable(memEn_o) &&
                                    $stable(memAddr_o) && $stable(memWdata_o) &&
                                    $stable(memWen_o)))
        else $error("core outputs moved during a stall");

    noZeroWrite: assert property (@(posedge clk) disable iff (rst_i)
        (dbgRfWen_o != 4'h0) |-> (dbgRfWnum_o != '0))
        else $error("trace reports a write to register zero");

endmodule

bind mipsCore tbMips_sva sva (.*);

// ==== vlog.f ====
mipsPkg.sv
stageReg.sv
fetchUnit.sv
regFile.sv
pipeCtrl.sv
execUnit.sv
memAccess.sv
mipsCore.sv
tbMips_sva.sv
tbMips.sv
